// ==== filelist.f ====
logic/ulpi_pkg.sv
logic/usb_link_pkg.sv
logic/ulpi_rx_cmd.sv
logic/usb_interval_timer.sv
logic/ulpi_tx_sequencer.sv
logic/line_state.sv
logic/ulpi_link_top.sv
tb/ulpi_phy_model.sv
tb/ulpi_link_tb.sv

// ==== Bender.yml ====
package:
  name: ulpi_link

sources:
  # Packages first, then the blocks and the top level
  - target: rtl
    files:
      - logic/ulpi_pkg.sv
      - logic/usb_link_pkg.sv
      - logic/ulpi_rx_cmd.sv
      - logic/usb_interval_timer.sv
      - logic/ulpi_tx_sequencer.sv
      - logic/line_state.sv
      - logic/ulpi_link_top.sv
  # Behavioral PHY and the testbench top
  - target: test
    files:
      - tb/ulpi_phy_model.sv
      - tb/ulpi_link_tb.sv

// ==== tb/ulpi_link_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module ulpi_link_tb;

  localparam int CLOCK_PERIOD = 40;
  localparam int COUNT_2_5US  = 7;
  localparam int COUNT_1_0MS  = 3;
  // Interval lengths in clock cycles
  localparam int INTERVAL_CYCLES = COUNT_2_5US + 1;
  localparam int MS_CYCLES       = INTERVAL_CYCLES * (COUNT_1_0MS + 1);
  // K/J symbol holds, spacing is hold plus two
  localparam int SHORT_HOLD = 3;
  localparam int LONG_HOLD  = 12;
  // Request, two bytes at up to four cycles each, stop
  localparam int WRITE_CYCLES   = 12;
  localparam int SCRIPT_CYCLES  = 8 + 5 * WRITE_CYCLES + INTERVAL_CYCLES + MS_CYCLES +
                                  4 * (SHORT_HOLD + 2) + 6 * (LONG_HOLD + 2);
  localparam int TIMEOUT_CYCLES = 4 * SCRIPT_CYCLES;
  localparam int EVENT_COUNT    = 6;

  logic        clock = 1'b0;
  logic        reset;
  logic        phy_dir;
  logic        phy_nxt;
  logic [7:0]  phy_data;
  logic [7:0]  link_data;
  logic        link_stp;
  logic [1:0]  line_state;
  logic [1:0]  vbus_state;
  logic [1:0]  rx_event;
  logic        high_speed;
  logic        chirp_kj;
  logic        usb_reset;
  // Model control and log
  logic        send_rx;
  logic [7:0]  rx_byte;
  logic        cut_write;
  logic        event_valid;
  logic [15:0] phy_event;

  int          value_errors = 0;
  int          other_errors = 0;
  int          event_index  = 0;
  int          chirp_pulses = 0;
  int          k_cycles;
  logic [15:0] exp_event;
  time         nopid_time;
  logic        stp_prev = 1'b0;
  logic        hs_prev  = 1'b0;
  logic        dir_prev = 1'b0;
  int          rx_age   = 0;
  logic [5:0]  rx_sent;
  logic [5:0]  rx_before;

  always #(CLOCK_PERIOD / 2) clock = ~clock;

  ulpi_link_top #(
    .COUNT_2_5US (COUNT_2_5US),
    .COUNT_1_0MS (COUNT_1_0MS)
  ) u_ulpi_link_top (
    .clock        (clock),
    .reset        (reset),
    .ulpi_dir_i   (phy_dir),
    .ulpi_nxt_i   (phy_nxt),
    .ulpi_data_i  (phy_data),
    .ulpi_data_o  (link_data),
    .ulpi_stp_o   (link_stp),
    .line_state_o (line_state),
    .vbus_state_o (vbus_state),
    .rx_event_o   (rx_event),
    .high_speed_o (high_speed),
    .chirp_kj_o   (chirp_kj),
    .usb_reset_o  (usb_reset)
  );

  ulpi_phy_model u_ulpi_phy_model (
    .clock         (clock),
    .reset         (reset),
    .ulpi_data_i   (link_data),
    .ulpi_stp_i    (link_stp),
    .ulpi_dir_o    (phy_dir),
    .ulpi_nxt_o    (phy_nxt),
    .ulpi_data_o   (phy_data),
    .send_i        (send_rx),
    .rx_byte_i     (rx_byte),
    .cut_write_i   (cut_write),
    .event_valid_o (event_valid),
    .event_o       (phy_event)
  );

  // Expected i-th transmit event as {kind, address, value}
  // Kind 1 register write, 2 NOPID start, 3 end of chirp K
  function automatic logic [15:0] expected_event(input int index);
    case (index)
      0:       return {2'd1, 6'h0A, 8'h00};  // OTG control default
      1:       return {2'd1, 6'h04, 8'h45};  // full speed
      2:       return {2'd1, 6'h04, 8'h54};  // chirp mode
      3:       return {2'd2, 6'h00, 8'h40};
      4:       return {2'd3, 6'h00, 8'h00};
      5:       return {2'd1, 6'h04, 8'h40};  // normal high speed
      default: return 16'hFFFF;
    endcase
  endfunction

  // One RX CMD from the model, then the line is held
  task automatic send_rx_cmd(input logic [7:0] cmd, input int hold_cycles);
    @(posedge clock);
    send_rx <= 1'b1;
    rx_byte <= cmd;
    @(posedge clock);
    send_rx <= 1'b0;
    repeat (hold_cycles) @(posedge clock);
  endtask

  // Compare process, sampled away from the driving edge
  always @(negedge clock) begin
    if (!reset) begin
      if (event_valid) begin
        exp_event = expected_event(event_index);
        assert (phy_event == exp_event) else begin
          value_errors++;
          $display("Mismatch at %0t: transmit event %0d is %h, expected %h",
                   $time, event_index, phy_event, exp_event);
        end
        if (phy_event[15:14] == 2'd2) begin
          nopid_time = $time;
        end
        if (phy_event[15:14] == 2'd3) begin
          k_cycles = int'(($time - nopid_time) / CLOCK_PERIOD);
          assert (k_cycles >= MS_CYCLES && k_cycles <= MS_CYCLES + 4) else begin
            other_errors++;
            $display("Chirp K lasted %0d cycles, not one 1.0 ms interval of %0d cycles",
                     k_cycles, MS_CYCLES);
          end
        end
        event_index++;
      end
      assert (!(link_stp && stp_prev)) else begin
        other_errors++;
        $display("stp stayed high for more than one cycle at %0t", $time);
      end
      assert (!(high_speed && !hs_prev) || stp_prev) else begin
        other_errors++;
        $display("High speed came up without a finished register write before it");
      end
      if (chirp_kj) begin
        chirp_pulses++;
      end
      // RX CMD on the pins is the byte after turnaround with nxt low
      if (phy_dir && dir_prev && !phy_nxt) begin
        rx_sent   = phy_data[5:0];
        rx_before = {rx_event, vbus_state, line_state};
        rx_age    = 1;
      end else if (rx_age == 1) begin
        assert ({rx_event, vbus_state, line_state} == rx_before) else begin
          value_errors++;
          $display("Mismatch at %0t: RX CMD fields changed one cycle early", $time);
        end
        rx_age = 2;
      end else if (rx_age == 2) begin
        assert ({rx_event, vbus_state, line_state} == rx_sent) else begin
          value_errors++;
          $display("Mismatch at %0t: RX CMD fields %b, expected %b", $time,
                   {rx_event, vbus_state, line_state}, rx_sent);
        end
        rx_age = 0;
      end
    end
    stp_prev = link_stp;
    hs_prev  = high_speed;
    dir_prev = phy_dir;
  end

  initial begin
    reset     = 1'b1;
    send_rx   = 1'b0;
    // RX CMD used to cut the first write, J with VBUS valid and event 01
    rx_byte   = 8'h1D;
    cut_write = 1'b1;
    repeat (3) @(posedge clock);
    @(negedge clock);
    assert (!link_stp && link_data == 8'h00 && !high_speed && line_state == 2'b01 &&
            usb_reset) else begin
      value_errors++;
      $display("Mismatch at %0t: reset state stp %b data %h hs %b line %b usb_reset %b",
               $time, link_stp, link_data, high_speed, line_state, usb_reset);
    end
    @(posedge clock);
    reset <= 1'b0;
    // Both full speed writes done, then SE0 with VBUS valid
    wait (event_index == 2);
    send_rx_cmd(8'h0C, 0);
    // Chirp mode write, NOPID and its stop
    wait (event_index == 5);
    repeat (2) @(posedge clock);
    // Symbols too short to count as chirps
    repeat (2) begin
      send_rx_cmd(8'h0E, SHORT_HOLD);
      send_rx_cmd(8'h0D, SHORT_HOLD);
    end
    assert (chirp_pulses == 0 && !high_speed && usb_reset) else begin
      value_errors++;
      $display("Mismatch at %0t: %0d chirps counted from short symbols, hs %b",
               $time, chirp_pulses, high_speed);
    end
    // Six valid host chirps
    repeat (3) begin
      send_rx_cmd(8'h0E, LONG_HOLD);
      send_rx_cmd(8'h0D, LONG_HOLD);
    end
    wait (event_index == EVENT_COUNT);
    @(negedge clock);
    assert (chirp_pulses == 6 && high_speed && !usb_reset) else begin
      value_errors++;
      $display("Mismatch at %0t: %0d chirp pulses, hs %b, usb_reset %b",
               $time, chirp_pulses, high_speed, usb_reset);
    end
    repeat (4) @(negedge clock);
    assert (event_index == EVENT_COUNT) else begin
      value_errors++;
      $display("Mismatch at %0t: %0d transmit events, expected %0d",
               $time, event_index, EVENT_COUNT);
    end
    $display("Checks done: %0d value mismatches, %0d other errors", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Watchdog sized from the scenario length
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clock);
    other_errors++;
    $display("Start-up hung, high speed not reached within %0d cycles", TIMEOUT_CYCLES);
    $display("Checks done: %0d value mismatches, %0d other errors", value_errors, other_errors);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/ulpi_phy_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module ulpi_phy_model (
  input  wire         clock,
  input  wire         reset,
  // Link side of the bus
  input  wire  [7:0]  ulpi_data_i,
  input  wire         ulpi_stp_i,
  output logic        ulpi_dir_o,
  output logic        ulpi_nxt_o,
  output logic [7:0]  ulpi_data_o,
  // Scenario control
  input  wire         send_i,
  input  wire  [7:0]  rx_byte_i,
  input  wire         cut_write_i,
  // Transmit log as {kind, address, value}
  output logic        event_valid_o,
  output logic [15:0] event_o
);

  // Log kinds
  localparam logic [1:0] EV_WRITE = 2'd1;
  localparam logic [1:0] EV_NOPID = 2'd2;
  localparam logic [1:0] EV_STOP  = 2'd3;

  // Transmit phases seen from the PHY side
  localparam int PH_IDLE   = 0;
  localparam int PH_VALUE  = 1;
  localparam int PH_STOP   = 2;
  localparam int PH_NOPID  = 3;
  localparam int PH_HOLD_K = 4;

  int          phase;
  // 0 idle, 1 turnaround, 2 RX CMD byte on the bus
  int          rx_step;
  logic [5:0]  addr;
  logic [7:0]  value;
  logic [15:0] lfsr;
  logic [1:0]  delay_left;
  // Delay drawn for the byte now on the bus
  logic        armed;
  logic        cut_done;

  // Fibonacci taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  task automatic log_event(input logic [15:0] ev);
    event_valid_o <= 1'b1;
    event_o       <= ev;
  endtask

  initial begin
    ulpi_dir_o    = 1'b0;
    ulpi_nxt_o    = 1'b0;
    ulpi_data_o   = 8'h00;
    event_valid_o = 1'b0;
    event_o       = 16'h0000;
  end

  always @(posedge clock) begin
    event_valid_o <= 1'b0;
    if (reset) begin
      ulpi_dir_o  <= 1'b0;
      ulpi_nxt_o  <= 1'b0;
      ulpi_data_o <= 8'h00;
      phase       = PH_IDLE;
      rx_step     = 0;
      armed       = 1'b0;
      cut_done    = 1'b0;
      delay_left  = 2'd0;
      lfsr        = 16'd60782;
    end else if (rx_step == 1) begin
      // Turnaround done, RX CMD byte goes out
      ulpi_data_o <= rx_byte_i;
      rx_step = 2;
    end else if (rx_step == 2) begin
      ulpi_dir_o  <= 1'b0;
      ulpi_data_o <= 8'h00;
      rx_step = 0;
    end else if (send_i) begin
      ulpi_dir_o <= 1'b1;
      rx_step = 1;
    end else if (ulpi_stp_i) begin
      if (phase == PH_STOP) begin
        log_event({EV_WRITE, addr, value});
      end else if (phase == PH_HOLD_K) begin
        log_event({EV_STOP, 14'h0000});
      end else begin
        // Stop out of place, kind 0 never matches
        log_event({2'd0, addr, value});
      end
      ulpi_nxt_o <= 1'b0;
      phase = PH_IDLE;
      armed = 1'b0;
    end else if (ulpi_nxt_o) begin
      // Byte on the bus is taken at this edge
      ulpi_nxt_o <= 1'b0;
      if (phase == PH_IDLE && ulpi_data_i[7:6] == 2'b10) begin
        addr  = ulpi_data_i[5:0];
        phase = PH_VALUE;
        if (cut_write_i && !cut_done) begin
          // Take the bus between command and value, write is dropped
          cut_done = 1'b1;
          phase    = PH_IDLE;
          rx_step  = 1;
          ulpi_dir_o <= 1'b1;
        end
      end else if (phase == PH_VALUE) begin
        value = ulpi_data_i;
        phase = PH_STOP;
      end else if (phase == PH_NOPID) begin
        phase = PH_HOLD_K;
      end
    end else if ((phase == PH_IDLE && ulpi_data_i != 8'h00) ||
                 phase == PH_VALUE || phase == PH_NOPID) begin
      if (phase == PH_IDLE && ulpi_data_i == 8'h40) begin
        log_event({EV_NOPID, 6'h00, ulpi_data_i});
        phase = PH_NOPID;
      end
      // nxt after 0 to 3 cycles, two LFSR bits
      if (!armed) begin
        lfsr = lfsr_next(lfsr);
        delay_left[0] = lfsr[0];
        lfsr = lfsr_next(lfsr);
        delay_left[1] = lfsr[0];
        armed = 1'b1;
      end
      if (delay_left == 2'd0) begin
        ulpi_nxt_o <= 1'b1;
        armed = 1'b0;
      end else begin
        delay_left = delay_left - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/ulpi_link_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module ulpi_link_top #(
  parameter int unsigned COUNT_2_5US = 149,
  parameter int unsigned COUNT_1_0MS = 399
) (
  input  wire                       clock,
  input  wire                       reset,
  // PHY pins
  input  wire                       ulpi_dir_i,
  input  wire                       ulpi_nxt_i,
  input  ulpi_pkg::ulpi_byte_t      ulpi_data_i,
  output ulpi_pkg::ulpi_byte_t      ulpi_data_o,
  output logic                      ulpi_stp_o,
  // Link status
  output usb_link_pkg::line_code_t  line_state_o,
  output usb_link_pkg::vbus_code_t  vbus_state_o,
  output usb_link_pkg::rx_event_t   rx_event_o,
  output logic                      high_speed_o,
  output logic                      chirp_kj_o,
  output logic                      usb_reset_o
);

  logic                 dir_busy;
  logic                 line_changed;
  logic                 pulse_2_5us;
  logic                 pulse_1_0ms;
  logic                 timer_restart;
  // Request/done handshake toward the sequencer
  logic                 tx_req;
  logic                 tx_nopid;
  ulpi_pkg::reg_addr_t  tx_addr;
  ulpi_pkg::ulpi_byte_t tx_value;
  logic                 tx_stop;
  logic                 tx_done;

  ulpi_rx_cmd u_ulpi_rx_cmd (
    .clock          (clock),
    .reset          (reset),
    .ulpi_dir_i     (ulpi_dir_i),
    .ulpi_nxt_i     (ulpi_nxt_i),
    .ulpi_data_i    (ulpi_data_i),
    .dir_busy_o     (dir_busy),
    .line_state_o   (line_state_o),
    .vbus_state_o   (vbus_state_o),
    .rx_event_o     (rx_event_o),
    .line_changed_o (line_changed)
  );

  usb_interval_timer #(
    .COUNT_2_5US (COUNT_2_5US),
    .COUNT_1_0MS (COUNT_1_0MS)
  ) u_usb_interval_timer (
    .clock         (clock),
    .reset         (reset),
    .restart_i     (timer_restart),
    .pulse_2_5us_o (pulse_2_5us),
    .pulse_1_0ms_o (pulse_1_0ms)
  );

  ulpi_tx_sequencer u_ulpi_tx_sequencer (
    .clock       (clock),
    .reset       (reset),
    .dir_busy_i  (dir_busy),
    .ulpi_nxt_i  (ulpi_nxt_i),
    .tx_req_i    (tx_req),
    .tx_nopid_i  (tx_nopid),
    .tx_addr_i   (tx_addr),
    .tx_value_i  (tx_value),
    .tx_stop_i   (tx_stop),
    .tx_done_o   (tx_done),
    .ulpi_data_o (ulpi_data_o),
    .ulpi_stp_o  (ulpi_stp_o)
  );

  line_state u_line_state (
    .clock           (clock),
    .reset           (reset),
    .line_state_i    (line_state_o),
    .line_changed_i  (line_changed),
    .pulse_2_5us_i   (pulse_2_5us),
    .pulse_1_0ms_i   (pulse_1_0ms),
    .tx_done_i       (tx_done),
    .tx_req_o        (tx_req),
    .tx_nopid_o      (tx_nopid),
    .tx_addr_o       (tx_addr),
    .tx_value_o      (tx_value),
    .tx_stop_o       (tx_stop),
    .timer_restart_o (timer_restart),
    .high_speed_o    (high_speed_o),
    .chirp_kj_o      (chirp_kj_o),
    .usb_reset_o     (usb_reset_o)
  );

endmodule

`default_nettype wire

// ==== logic/line_state.sv ====
`timescale 1ns/1ns
`default_nettype none

module line_state (
  input  wire                       clock,
  input  wire                       reset,
  input  usb_link_pkg::line_code_t  line_state_i,
  input  wire                       line_changed_i,
  input  wire                       pulse_2_5us_i,
  input  wire                       pulse_1_0ms_i,
  input  wire                       tx_done_i,
  output logic                      tx_req_o,
  output logic                      tx_nopid_o,
  output ulpi_pkg::reg_addr_t       tx_addr_o,
  output ulpi_pkg::ulpi_byte_t      tx_value_o,
  output logic                      tx_stop_o,
  output logic                      timer_restart_o,
  output logic                      high_speed_o,
  output logic                      chirp_kj_o,
  output logic                      usb_reset_o
);

  usb_link_pkg::startup_state_e state_q;
  usb_link_pkg::startup_state_e write_next;
  usb_link_pkg::chirp_count_t   kj_count_q;
  usb_link_pkg::chirp_count_t   kj_count_next;

  // Request for the current state already raised
  logic tx_sent_q;
  // Timer restart on entry to a timed state
  logic entry_restart_q;
  // Symbol seen, waiting for one full interval
  logic kj_armed_q;
  logic fresh_2_5us;
  logic fresh_1_0ms;
  logic kj_line;

  // Restart at wait entry and at each line change while measuring
  assign timer_restart_o = entry_restart_q ||
    (line_changed_i && (state_q == usb_link_pkg::WAIT_SE0 ||
                        state_q == usb_link_pkg::CHIRP_KJ));

  // Pulses from an interval that a restart just cut short are ignored
  assign fresh_2_5us = pulse_2_5us_i && !timer_restart_o;
  assign fresh_1_0ms = pulse_1_0ms_i && !timer_restart_o;

  assign kj_line = (line_state_i == usb_link_pkg::LINE_K) ||
                   (line_state_i == usb_link_pkg::LINE_J);

  assign kj_count_next = kj_count_q + 1'b1;

  // Transmit request contents and the state after each register write
  always_comb begin
    tx_nopid_o = 1'b0;
    tx_addr_o  = ulpi_pkg::REG_FUNC_CTRL;
    tx_value_o = ulpi_pkg::FUNC_HS_MODE;
    write_next = usb_link_pkg::HS_MODE;
    case (state_q)
      usb_link_pkg::FS_OTG: begin
        tx_addr_o  = ulpi_pkg::REG_OTG_CTRL;
        tx_value_o = ulpi_pkg::OTG_DEFAULT;
        write_next = usb_link_pkg::FS_FUNC;
      end
      usb_link_pkg::FS_FUNC: begin
        tx_value_o = ulpi_pkg::FUNC_FS_MODE;
        write_next = usb_link_pkg::WAIT_SE0;
      end
      usb_link_pkg::CHIRP_MODE: begin
        tx_value_o = ulpi_pkg::FUNC_CHIRP_MODE;
        write_next = usb_link_pkg::CHIRP_K;
      end
      usb_link_pkg::CHIRP_K, usb_link_pkg::CHIRP_END: begin
        tx_nopid_o = 1'b1;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q         <= usb_link_pkg::POWER_ON;
      tx_req_o        <= 1'b0;
      tx_sent_q       <= 1'b0;
      tx_stop_o       <= 1'b0;
      entry_restart_q <= 1'b0;
      chirp_kj_o      <= 1'b0;
      kj_armed_q      <= 1'b0;
      kj_count_q      <= '0;
    end else begin
      // Single-cycle strobes
      tx_stop_o       <= 1'b0;
      entry_restart_q <= 1'b0;
      chirp_kj_o      <= 1'b0;
      case (state_q)
        usb_link_pkg::POWER_ON: begin
          state_q <= usb_link_pkg::FS_OTG;
        end
        usb_link_pkg::FS_OTG, usb_link_pkg::FS_FUNC,
        usb_link_pkg::CHIRP_MODE, usb_link_pkg::HS_START: begin
          // Raise once, hold until done, then move on
          if (!tx_sent_q) begin
            tx_req_o  <= 1'b1;
            tx_sent_q <= 1'b1;
          end else if (tx_done_i) begin
            tx_req_o  <= 1'b0;
            tx_sent_q <= 1'b0;
            state_q   <= write_next;
            // SE0 is measured from a fresh interval
            entry_restart_q <= (write_next == usb_link_pkg::WAIT_SE0);
          end
        end
        usb_link_pkg::WAIT_SE0: begin
          // Bus reset seen for one whole 2.5 us interval
          if (fresh_2_5us && line_state_i == usb_link_pkg::LINE_SE0) begin
            state_q <= usb_link_pkg::CHIRP_MODE;
          end
        end
        usb_link_pkg::CHIRP_K: begin
          // NOPID starts chirp K and the 1.0 ms count with it
          if (!tx_sent_q) begin
            tx_req_o        <= 1'b1;
            tx_sent_q       <= 1'b1;
            entry_restart_q <= 1'b1;
          end else if (fresh_1_0ms) begin
            tx_stop_o <= 1'b1;
            state_q   <= usb_link_pkg::CHIRP_END;
          end
        end
        usb_link_pkg::CHIRP_END: begin
          if (tx_done_i) begin
            tx_req_o   <= 1'b0;
            tx_sent_q  <= 1'b0;
            kj_armed_q <= 1'b0;
            kj_count_q <= '0;
            state_q    <= usb_link_pkg::CHIRP_KJ;
          end
        end
        usb_link_pkg::CHIRP_KJ: begin
          // Each new K or J arms the check, SE0 disarms it
          if (line_changed_i) begin
            kj_armed_q <= kj_line;
          end else if (kj_armed_q && fresh_2_5us) begin
            kj_armed_q <= 1'b0;
            chirp_kj_o <= 1'b1;
            kj_count_q <= kj_count_next;
            if (kj_count_next == usb_link_pkg::CHIRP_PAIRS_NEEDED) begin
              state_q <= usb_link_pkg::HS_START;
            end
          end
        end
        usb_link_pkg::HS_MODE: begin
          state_q <= usb_link_pkg::HS_MODE;
        end
        default: begin
          state_q <= usb_link_pkg::POWER_ON;
        end
      endcase
    end
  end

  assign high_speed_o = (state_q == usb_link_pkg::HS_MODE);

  // Core is held in reset until the handshake has finished
  assign usb_reset_o = (state_q != usb_link_pkg::HS_START) &&
                       (state_q != usb_link_pkg::HS_MODE);

  // Request stays up until the sequencer answers
  req_held_until_done : assert property (
    @(posedge clock) disable iff (reset)
    $fell(tx_req_o) |-> $past(tx_done_i)
  );

endmodule

`default_nettype wire

// ==== logic/ulpi_tx_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module ulpi_tx_sequencer (
  input  wire                   clock,
  input  wire                   reset,
  input  wire                   dir_busy_i,
  input  wire                   ulpi_nxt_i,
  input  wire                   tx_req_i,
  input  wire                   tx_nopid_i,
  input  ulpi_pkg::reg_addr_t   tx_addr_i,
  input  ulpi_pkg::ulpi_byte_t  tx_value_i,
  input  wire                   tx_stop_i,
  output logic                  tx_done_o,
  output ulpi_pkg::ulpi_byte_t  ulpi_data_o,
  output logic                  ulpi_stp_o
);

  // Phases of one transmit
  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_CMD,
    SEQ_VALUE,
    SEQ_HOLD_K,
    SEQ_STOP
  } seq_state_e;

  seq_state_e           state_q;
  ulpi_pkg::ulpi_byte_t cmd_byte;
  ulpi_pkg::ulpi_byte_t drive_byte;

  // Command byte from the request
  assign cmd_byte = tx_nopid_i ? ulpi_pkg::TX_NOPID : {ulpi_pkg::TX_REG_WRITE, tx_addr_i};

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= SEQ_IDLE;
    end else begin
      case (state_q)
        SEQ_IDLE: begin
          // Also the restart point after the PHY took the bus
          if (tx_req_i && !dir_busy_i) begin
            state_q <= SEQ_CMD;
          end
        end
        SEQ_CMD: begin
          if (dir_busy_i) begin
            state_q <= SEQ_IDLE;
          end else if (ulpi_nxt_i) begin
            state_q <= tx_nopid_i ? SEQ_HOLD_K : SEQ_VALUE;
          end
        end
        SEQ_VALUE: begin
          if (dir_busy_i) begin
            state_q <= SEQ_IDLE;
          end else if (ulpi_nxt_i) begin
            state_q <= SEQ_STOP;
          end
        end
        SEQ_HOLD_K: begin
          // Chirp K lasts until the FSM asks for a stop
          if (dir_busy_i) begin
            state_q <= SEQ_IDLE;
          end else if (tx_stop_i) begin
            state_q <= SEQ_STOP;
          end
        end
        SEQ_STOP: begin
          state_q <= SEQ_IDLE;
        end
        default: begin
          state_q <= SEQ_IDLE;
        end
      endcase
    end
  end

  // Byte for the current phase
  always_comb begin
    case (state_q)
      SEQ_CMD:   drive_byte = cmd_byte;
      SEQ_VALUE: drive_byte = tx_value_i;
      default:   drive_byte = '0;
    endcase
  end

  // Bus idles at 00 while the PHY drives it
  assign ulpi_data_o = dir_busy_i ? '0 : drive_byte;
  assign ulpi_stp_o  = (state_q == SEQ_STOP);
  assign tx_done_o   = (state_q == SEQ_STOP);

  // Stop follows an accepted byte or a stop request, and lasts one cycle
  stp_one_cycle : assert property (
    @(posedge clock) disable iff (reset)
    ulpi_stp_o |-> $past(ulpi_nxt_i || tx_stop_i) ##1 !ulpi_stp_o
  );

  // Done answers a request that was already pending
  done_needs_req : assert property (
    @(posedge clock) disable iff (reset)
    tx_done_o |-> tx_req_i && $past(tx_req_i)
  );

endmodule

`default_nettype wire

// ==== logic/usb_interval_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

module usb_interval_timer #(
  parameter int unsigned COUNT_2_5US = 149,
  parameter int unsigned COUNT_1_0MS = 399
) (
  input  wire  clock,
  input  wire  reset,
  input  wire  restart_i,
  output logic pulse_2_5us_o,
  output logic pulse_1_0ms_o
);

  // Counter widths, at least one bit each
  localparam int FAST_W = (COUNT_2_5US > 0) ? $clog2(COUNT_2_5US + 1) : 1;
  localparam int SLOW_W = (COUNT_1_0MS > 0) ? $clog2(COUNT_1_0MS + 1) : 1;

  logic [FAST_W-1:0] fast_q;
  logic [SLOW_W-1:0] slow_q;
  logic              fast_wrap;

  // Fast counter at its last value and no restart pending
  assign fast_wrap = !restart_i && (fast_q == FAST_W'(COUNT_2_5US));

  // 2.5 us counter, one pulse per COUNT_2_5US+1 cycles
  always_ff @(posedge clock) begin
    if (reset || restart_i) begin
      fast_q        <= '0;
      pulse_2_5us_o <= 1'b0;
    end else if (fast_wrap) begin
      fast_q        <= '0;
      pulse_2_5us_o <= 1'b1;
    end else begin
      fast_q        <= fast_q + 1'b1;
      pulse_2_5us_o <= 1'b0;
    end
  end

  // 1.0 ms counter, steps on each 2.5 us wrap
  // Pulse is aligned with the 2.5 us pulse that completes the count
  always_ff @(posedge clock) begin
    if (reset || restart_i) begin
      slow_q        <= '0;
      pulse_1_0ms_o <= 1'b0;
    end else if (fast_wrap) begin
      if (slow_q == SLOW_W'(COUNT_1_0MS)) begin
        slow_q        <= '0;
        pulse_1_0ms_o <= 1'b1;
      end else begin
        slow_q        <= slow_q + 1'b1;
        pulse_1_0ms_o <= 1'b0;
      end
    end else begin
      pulse_1_0ms_o <= 1'b0;
    end
  end

  // A restart always opens a fresh interval
  no_pulse_after_restart : assert property (
    @(posedge clock) disable iff (reset)
    $past(restart_i) |-> !pulse_2_5us_o && !pulse_1_0ms_o
  );

endmodule

`default_nettype wire

// ==== logic/ulpi_rx_cmd.sv ====
`timescale 1ns/1ns
`default_nettype none

module ulpi_rx_cmd (
  input  wire                       clock,
  input  wire                       reset,
  input  wire                       ulpi_dir_i,
  input  wire                       ulpi_nxt_i,
  input  ulpi_pkg::ulpi_byte_t      ulpi_data_i,
  output logic                      dir_busy_o,
  output usb_link_pkg::line_code_t  line_state_o,
  output usb_link_pkg::vbus_code_t  vbus_state_o,
  output usb_link_pkg::rx_event_t   rx_event_o,
  output logic                      line_changed_o
);

  // Pin registers, meant to be packed into the IOBs
  logic                 dir_q;
  logic                 nxt_q;
  ulpi_pkg::ulpi_byte_t data_q;
  // Registered dir one cycle further back, marks the turnaround cycle
  logic                 dir_prev_q;
  logic                 rx_cmd;

  always_ff @(posedge clock) begin
    dir_q      <= ulpi_dir_i;
    nxt_q      <= ulpi_nxt_i;
    data_q     <= ulpi_data_i;
    dir_prev_q <= dir_q;
  end

  // PHY owns the bus past turnaround and nxt is low
  assign rx_cmd = dir_q && dir_prev_q && !nxt_q;

  // Link must keep off the bus while dir is high or just fell
  assign dir_busy_o = ulpi_dir_i || dir_q;

  // Decoded fields, updated only by RX CMD bytes
  always_ff @(posedge clock) begin
    if (reset) begin
      line_state_o   <= usb_link_pkg::LINE_J;
      vbus_state_o   <= '0;
      rx_event_o     <= '0;
      line_changed_o <= 1'b0;
    end else begin
      // Pulse lines up with the new line state
      line_changed_o <= rx_cmd && (data_q[1:0] != line_state_o);
      if (rx_cmd) begin
        line_state_o <= data_q[1:0];
        vbus_state_o <= data_q[3:2];
        rx_event_o   <= data_q[5:4];
      end
    end
  end

  // PHY never raises nxt while dir is turning around
  nxt_quiet_in_turnaround : assert property (
    @(posedge clock) disable iff (reset)
    (ulpi_dir_i != dir_q) |-> !$rose(ulpi_nxt_i)
  );

endmodule

`default_nettype wire

// ==== logic/usb_link_pkg.sv ====
`default_nettype none

package usb_link_pkg;

  // UTMI line state as carried in RX CMD bits 1:0
  typedef logic [1:0] line_code_t;

  localparam line_code_t LINE_SE0 = 2'b00;
  localparam line_code_t LINE_J   = 2'b01;
  localparam line_code_t LINE_K   = 2'b10;

  // VBUS state from RX CMD bits 3:2
  typedef logic [1:0] vbus_code_t;
  // RX event from RX CMD bits 5:4
  typedef logic [1:0] rx_event_t;

  // Start-up sequence of the link
  typedef enum logic [3:0] {
    POWER_ON,
    FS_OTG,
    FS_FUNC,
    WAIT_SE0,
    CHIRP_MODE,
    CHIRP_K,
    CHIRP_END,
    CHIRP_KJ,
    HS_START,
    HS_MODE
  } startup_state_e;

  // Count of valid host chirps
  typedef logic [2:0] chirp_count_t;

  // Host K/J chirps needed before high speed is entered
  localparam chirp_count_t CHIRP_PAIRS_NEEDED = 3'd6;

endpackage

`default_nettype wire

// ==== logic/ulpi_pkg.sv ====
`default_nettype none

package ulpi_pkg;

  // One byte on the ULPI data bus
  typedef logic [7:0] ulpi_byte_t;

  // Register address field of a transmit command
  typedef logic [5:0] reg_addr_t;

  // Transmit command prefixes and codes
  // Immediate register write is 10 followed by the 6-bit address
  localparam logic [1:0] TX_REG_WRITE = 2'b10;
  // NOPID transmit, the PHY sends chirp K while data stays 00
  localparam ulpi_byte_t TX_NOPID = 8'h40;

  // PHY register addresses
  localparam reg_addr_t REG_FUNC_CTRL = 6'h04;
  localparam reg_addr_t REG_OTG_CTRL  = 6'h0A;

  // Function control values
  // Full speed transceiver, normal operation
  localparam ulpi_byte_t FUNC_FS_MODE    = 8'h45;
  // High speed transceiver in chirp mode
  localparam ulpi_byte_t FUNC_CHIRP_MODE = 8'h54;
  // High speed transceiver, normal operation
  localparam ulpi_byte_t FUNC_HS_MODE    = 8'h40;

  // OTG control value, pull-downs and VBUS drive off
  localparam ulpi_byte_t OTG_DEFAULT = 8'h00;

endpackage

`default_nettype wire
